/* source/fc_mem_pkg.sv */
////////////////////
// buffer memory map, word and address widths
// and the owner encoding of the memory port
////////////////////
package fc_mem_pkg;

  localparam int MEM_ADDR_W = 11;
  localparam int MEM_DEPTH  = 2048;
  localparam int WORD_W     = 32;

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [WORD_W-1:0]     mem_word_t;

  // region bases
  localparam mem_addr_t FEATURE_BASE = 11'd0;
  localparam mem_addr_t BIAS_BASE    = 11'd64;
  localparam mem_addr_t RESULT_BASE  = 11'd128;
  localparam mem_addr_t WEIGHT_BASE  = 11'd256;

  // layer size limits
  localparam int MAX_IN_WORDS = 16;
  localparam int MAX_OUTPUTS  = 64;

  // client that drives the single memory port
  typedef enum logic [1:0] {
    OWN_LOAD = 2'd0,
    OWN_CALC = 2'd1,
    OWN_SEND = 2'd2
  } mem_owner_t;

endpackage

/* source/fc_arith_pkg.sv */
////////////////////
// int8 lane and accumulator types, quantization
// constants and layer index types
////////////////////
package fc_arith_pkg;

  // four int8 lanes per 32-bit word
  localparam int LANES = 4;

  typedef logic signed [7:0] lane_t;

  // wide enough for 64 products plus a scaled bias
  localparam int ACC_W = 23;

  typedef logic signed [ACC_W-1:0] acc_t;

  // bias is added at the product scale
  localparam int BIAS_SHIFT = 6;

  // accumulator slice kept as the int8 result
  localparam int Q_LSB = 6;
  localparam int Q_MSB = 13;

  // output neuron index, 0 to 64
  typedef logic [6:0] out_idx_t;

  // feature word index, 0 to 16
  typedef logic [4:0] in_idx_t;

endpackage

/* source/fc_buffer_mem.sv */
////////////////////
// single-port buffer memory, port shared by owner
////////////////////
module fc_buffer_mem
  import fc_mem_pkg::*;
(
  input  logic       clk,
  input  mem_owner_t mem_owner,
  input  logic       load_wr_en,
  input  mem_addr_t  load_wr_addr,
  input  mem_word_t  load_wr_data,
  input  logic       calc_en,
  input  logic       calc_we,
  input  mem_addr_t  calc_addr,
  input  mem_word_t  calc_wdata,
  input  logic       send_en,
  input  mem_addr_t  send_addr,
  output mem_word_t  rd_data
);

  mem_word_t mem [MEM_DEPTH];

  logic      en;
  logic      we;
  mem_addr_t addr;
  mem_word_t wdata;

  // port mux
  always_comb begin
    en    = 1'b0;
    we    = 1'b0;
    addr  = send_addr;
    wdata = load_wr_data;
    case (mem_owner)
      OWN_LOAD: begin
        en   = load_wr_en;
        we   = load_wr_en;
        addr = load_wr_addr;
      end
      OWN_CALC: begin
        en    = calc_en;
        we    = calc_we;
        addr  = calc_addr;
        wdata = calc_wdata;
      end
      OWN_SEND: en = send_en;
      default:  en = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) mem[addr] <= wdata;
      else    rd_data   <= mem[addr];
    end
  end

  a_no_wr_in_send: assert property (@(posedge clk)
    mem_owner == OWN_SEND |-> !(load_wr_en || calc_we));

endmodule

/* source/fc_stream_loader.sv */
////////////////////
// input stream loader for feature, bias and weight bursts
////////////////////
module fc_stream_loader
  import fc_mem_pkg::*;
  import fc_arith_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      fc_start,
  input  mem_word_t s_tdata,
  input  logic      s_tvalid,
  input  logic      s_tlast,
  output logic      s_tready,
  output logic      load_wr_en,
  output mem_addr_t load_wr_addr,
  output mem_word_t load_wr_data,
  output in_idx_t   in_words,
  output logic      load_done
);

  typedef enum logic [1:0] {RG_IDLE, RG_FEAT, RG_BIAS, RG_WGT} region_t;

  region_t   region;
  mem_addr_t beat_cnt;
  mem_addr_t region_base;
  logic      beat;

  assign beat = s_tvalid && s_tready;

  always_comb begin
    case (region)
      RG_BIAS: region_base = BIAS_BASE;
      RG_WGT:  region_base = WEIGHT_BASE;
      default: region_base = FEATURE_BASE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      region     <= RG_IDLE;
      beat_cnt   <= '0;
      s_tready   <= 1'b0;
      in_words   <= '0;
      load_done  <= 1'b0;
      load_wr_en <= 1'b0;
    end else begin
      load_done  <= 1'b0;
      load_wr_en <= beat;
      if (region == RG_IDLE) begin
        if (fc_start) begin
          s_tready <= 1'b1;
          beat_cnt <= '0;
          region   <= RG_FEAT;
        end
      end else if (beat) begin
        if (s_tlast) begin
          // tlast closes the region
          beat_cnt <= '0;
          case (region)
            RG_FEAT: begin
              in_words <= in_idx_t'(beat_cnt + 1'b1);
              region   <= RG_BIAS;
            end
            RG_BIAS: region <= RG_WGT;
            default: begin
              s_tready  <= 1'b0;
              load_done <= 1'b1;
              region    <= RG_IDLE;
            end
          endcase
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      load_wr_addr <= region_base + beat_cnt;
      load_wr_data <= s_tdata;
    end
  end

  a_feat_limit: assert property (@(posedge clk) disable iff (!rstn)
    (region == RG_FEAT && beat) |-> beat_cnt < MAX_IN_WORDS);

endmodule

/* source/fc_mac_unit.sv */
////////////////////
// four-lane int8 MAC with bias, quantize,
// ReLU and result byte packing
////////////////////
module fc_mac_unit
  import fc_mem_pkg::*;
  import fc_arith_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  mem_word_t  rd_data,
  input  logic       acc_clear,
  input  logic       cap_feature,
  input  logic       cap_weight,
  input  logic       cap_bias,
  input  logic [1:0] bias_lane,
  input  logic       finish,
  input  logic [1:0] out_lane,
  output mem_word_t  packed_word
);

  lane_t feat [LANES];
  lane_t wgt  [LANES];
  logic  mac_pending;
  acc_t  acc;
  acc_t  prod_sum;
  acc_t  bias_term;
  lane_t bias_val;
  lane_t q_val;
  lane_t relu_val;

  // dot product of the captured lanes
  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      prod_sum = prod_sum + acc_t'(feat[i] * wgt[i]);
    end
  end

  assign bias_val  = lane_t'(rd_data[8*bias_lane +: 8]);
  assign bias_term = acc_t'(bias_val) <<< BIAS_SHIFT;

  // saturate unless all bits above the slice match its sign
  always_comb begin
    if (&acc[ACC_W-1:Q_MSB] || ~|acc[ACC_W-1:Q_MSB]) begin
      q_val = $signed(acc[Q_MSB:Q_LSB]);
    end else if (acc[ACC_W-1]) begin
      q_val = -8'sd128;
    end else begin
      q_val = 8'sd127;
    end
  end

  assign relu_val = q_val[7] ? 8'sd0 : q_val;

  // accumulate one cycle after the weight capture
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) mac_pending <= 1'b0;
    else       mac_pending <= cap_weight;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (cap_feature) feat[i] <= rd_data[8*i +: 8];
      if (cap_weight)  wgt[i]  <= rd_data[8*i +: 8];
    end
    if (acc_clear)        acc <= '0;
    else if (mac_pending) acc <= acc + prod_sum;
    else if (cap_bias)    acc <= acc + bias_term;
    if (finish) begin
      // lane 0 starts a fresh word
      if (out_lane == 2'd0) packed_word <= {{(WORD_W - 8){1'b0}}, relu_val};
      else                  packed_word[8*out_lane +: 8] <= relu_val;
    end
  end

endmodule

/* source/fc_result_sender.sv */
////////////////////
// result word reader and output stream driver
////////////////////
module fc_result_sender
  import fc_mem_pkg::*;
  import fc_arith_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      send_start,
  input  logic [$clog2(MAX_OUTPUTS / LANES):0] res_words,
  input  mem_word_t rd_data,
  input  logic      m_tready,
  output logic      send_en,
  output mem_addr_t send_addr,
  output mem_word_t m_tdata,
  output logic      m_tvalid,
  output logic      m_tlast,
  output logic      send_done
);

  typedef enum logic [1:0] {SD_IDLE, SD_READ, SD_WAIT, SD_HOLD} state_t;

  state_t state;
  logic [$clog2(MAX_OUTPUTS / LANES):0] words_q;
  logic [$clog2(MAX_OUTPUTS / LANES):0] word_idx;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= SD_IDLE;
      words_q   <= '0;
      word_idx  <= '0;
      send_en   <= 1'b0;
      send_addr <= '0;
      m_tvalid  <= 1'b0;
      m_tlast   <= 1'b0;
      send_done <= 1'b0;
    end else begin
      send_done <= 1'b0;
      case (state)
        SD_IDLE: begin
          if (send_start) begin
            words_q   <= res_words;
            word_idx  <= '0;
            send_en   <= 1'b1;
            send_addr <= RESULT_BASE;
            state     <= SD_READ;
          end
        end
        SD_READ: begin
          send_en <= 1'b0;
          state   <= SD_WAIT;
        end
        SD_WAIT: begin
          // read data valid here
          m_tvalid <= 1'b1;
          m_tlast  <= (word_idx == words_q - 1'b1);
          state    <= SD_HOLD;
        end
        SD_HOLD: begin
          if (m_tready) begin
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
            if (m_tlast) begin
              send_done <= 1'b1;
              state     <= SD_IDLE;
            end else begin
              word_idx  <= word_idx + 1'b1;
              send_en   <= 1'b1;
              send_addr <= RESULT_BASE + mem_addr_t'(word_idx + 1'b1);
              state     <= SD_READ;
            end
          end
        end
        default: state <= SD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SD_WAIT) m_tdata <= rd_data;
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

/* source/fc_ctrl.sv */
////////////////////
// control FSM for load, compute and send phases
////////////////////
module fc_ctrl
  import fc_mem_pkg::*;
  import fc_arith_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       fc_start,
  input  out_idx_t   out_size,
  input  logic       load_done,
  input  in_idx_t    in_words,
  input  logic       send_done,
  input  mem_word_t  packed_word,
  output mem_owner_t mem_owner,
  output logic       calc_en,
  output logic       calc_we,
  output mem_addr_t  calc_addr,
  output mem_word_t  calc_wdata,
  output logic       acc_clear,
  output logic       cap_feature,
  output logic       cap_weight,
  output logic       cap_bias,
  output logic [1:0] bias_lane,
  output logic       finish,
  output logic [1:0] out_lane,
  output logic       send_start,
  output logic [$clog2(MAX_OUTPUTS / LANES):0] res_words,
  output logic       fc_done
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_LOAD, ST_FETCH, ST_MAC, ST_BIAS, ST_STORE, ST_SEND
  } state_t;

  state_t    state;
  logic [1:0] step;
  out_idx_t  out_size_q;
  out_idx_t  out_idx;
  in_idx_t   in_words_q;
  in_idx_t   in_idx;
  logic      last_out;
  logic [6:0] res_sum;
  mem_addr_t weight_addr;

  // result word is the MAC's packed lanes
  assign calc_wdata  = packed_word;
  assign last_out    = (out_idx == out_size_q - 1'b1);
  assign res_sum     = out_size_q + 7'd3;
  // row-major weights, in_words words per output
  assign weight_addr = WEIGHT_BASE + mem_addr_t'(out_idx) * mem_addr_t'(in_words_q)
                       + mem_addr_t'(in_idx);

  always_comb begin
    case (state)
      ST_FETCH, ST_MAC, ST_BIAS, ST_STORE: mem_owner = OWN_CALC;
      ST_SEND:                             mem_owner = OWN_SEND;
      default:                             mem_owner = OWN_LOAD;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= ST_IDLE;
      step        <= '0;
      out_size_q  <= '0;
      out_idx     <= '0;
      in_words_q  <= '0;
      in_idx      <= '0;
      calc_en     <= 1'b0;
      calc_we     <= 1'b0;
      calc_addr   <= '0;
      acc_clear   <= 1'b0;
      cap_feature <= 1'b0;
      cap_weight  <= 1'b0;
      cap_bias    <= 1'b0;
      bias_lane   <= '0;
      finish      <= 1'b0;
      out_lane    <= '0;
      send_start  <= 1'b0;
      res_words   <= '0;
      fc_done     <= 1'b0;
    end else begin
      // one-cycle strobes
      acc_clear   <= 1'b0;
      cap_feature <= 1'b0;
      cap_weight  <= 1'b0;
      cap_bias    <= 1'b0;
      finish      <= 1'b0;
      send_start  <= 1'b0;
      fc_done     <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (fc_start) begin
            out_size_q <= out_size;
            state      <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (load_done) begin
            in_words_q <= in_words;
            out_idx    <= '0;
            in_idx     <= '0;
            step       <= '0;
            acc_clear  <= 1'b1;
            state      <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          // feature read, weight read, then capture each a cycle later
          step <= step + 1'b1;
          case (step)
            2'd0: begin
              calc_en   <= 1'b1;
              calc_addr <= FEATURE_BASE + mem_addr_t'(in_idx);
            end
            2'd1: begin
              calc_addr   <= weight_addr;
              cap_feature <= 1'b1;
            end
            2'd2: begin
              calc_en    <= 1'b0;
              cap_weight <= 1'b1;
            end
            default: state <= ST_MAC;
          endcase
        end
        ST_MAC: begin
          if (in_idx == in_words_q - 1'b1) begin
            in_idx <= '0;
            state  <= ST_BIAS;
          end else begin
            in_idx <= in_idx + 1'b1;
            state  <= ST_FETCH;
          end
        end
        ST_BIAS: begin
          step <= step + 1'b1;
          case (step)
            2'd0: begin
              calc_en   <= 1'b1;
              calc_addr <= BIAS_BASE + mem_addr_t'(out_idx[6:2]);
            end
            2'd1: begin
              calc_en   <= 1'b0;
              cap_bias  <= 1'b1;
              bias_lane <= out_idx[1:0];
            end
            default: begin
              step     <= '0;
              finish   <= 1'b1;
              out_lane <= out_idx[1:0];
              state    <= ST_STORE;
            end
          endcase
        end
        ST_STORE: begin
          if (step == 2'd0) begin
            step      <= 2'd1;
            acc_clear <= 1'b1;
            // write once the word is full or the layer ends
            if (out_idx[1:0] == 2'd3 || last_out) begin
              calc_en   <= 1'b1;
              calc_we   <= 1'b1;
              calc_addr <= RESULT_BASE + mem_addr_t'(out_idx[6:2]);
            end
          end else begin
            step    <= '0;
            calc_en <= 1'b0;
            calc_we <= 1'b0;
            if (last_out) begin
              send_start <= 1'b1;
              res_words  <= res_sum[6:2];
              state      <= ST_SEND;
            end else begin
              out_idx <= out_idx + 1'b1;
              state   <= ST_FETCH;
            end
          end
        end
        ST_SEND: begin
          if (send_done) begin
            fc_done <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_we_in_store: assert property (@(posedge clk) disable iff (!rstn)
    $rose(calc_we) |-> state == ST_STORE);

endmodule

/* source/fc_top.sv */
////////////////////
// fc layer engine top level
////////////////////
module fc_top
  import fc_mem_pkg::*;
  import fc_arith_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  mem_word_t s_tdata,
  input  logic      s_tvalid,
  input  logic      s_tlast,
  output logic      s_tready,
  output mem_word_t m_tdata,
  output logic      m_tvalid,
  output logic      m_tlast,
  input  logic      m_tready,
  input  logic      fc_start,
  input  out_idx_t  out_size,
  output logic      fc_done
);

  mem_owner_t mem_owner;
  logic       load_wr_en;
  mem_addr_t  load_wr_addr;
  mem_word_t  load_wr_data;
  logic       calc_en;
  logic       calc_we;
  mem_addr_t  calc_addr;
  mem_word_t  calc_wdata;
  logic       send_en;
  mem_addr_t  send_addr;
  mem_word_t  rd_data;
  mem_word_t  packed_word;
  in_idx_t    in_words;
  logic       load_done;
  logic       acc_clear;
  logic       cap_feature;
  logic       cap_weight;
  logic       cap_bias;
  logic [1:0] bias_lane;
  logic       finish;
  logic [1:0] out_lane;
  logic       send_start;
  logic       send_done;
  logic [$clog2(MAX_OUTPUTS / LANES):0] res_words;

  fc_ctrl u_ctrl (.*);

  fc_stream_loader u_loader (.*);

  fc_buffer_mem u_mem (.*);

  fc_mac_unit u_mac (.*);

  fc_result_sender u_sender (.*);

endmodule

/* dv/fc_tb.sv */
////////////////////
// fc layer testbench: stimulus, reference model,
// output checker and timeout
////////////////////
module fc_tb
  import fc_mem_pkg::*;
  import fc_arith_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RUNS      = 6;
  localparam int WORST_OUT = 16;
  localparam int WORST_IN  = 8;
  // load with input gaps, compute per output, send under back-pressure
  localparam int WORST_RUN = 2 * (WORST_IN + WORST_OUT / 4 + WORST_OUT * WORST_IN)
                             + WORST_OUT * (5 * WORST_IN + 5) + (WORST_OUT / 4) * 8 + 20;
  localparam int TIMEOUT_CYCLES = (RUNS * WORST_RUN + 10) * 4;

  logic      clk;
  logic      rstn;
  mem_word_t s_tdata;
  logic      s_tvalid;
  logic      s_tlast;
  logic      s_tready;
  mem_word_t m_tdata;
  logic      m_tvalid;
  logic      m_tlast;
  logic      m_tready;
  logic      fc_start;
  out_idx_t  out_size;
  logic      fc_done;

  // layer data as streamed to the DUT
  mem_word_t feat_words [MAX_IN_WORDS];
  mem_word_t bias_words [MAX_OUTPUTS / LANES];
  mem_word_t wgt_words  [MAX_IN_WORDS * MAX_OUTPUTS];
  int        cur_out;
  int        cur_in;

  mem_word_t   exp_q [$];
  logic        last_q [$];
  mem_word_t   exp_word;
  logic        exp_last;
  mem_word_t   last_word;
  logic [31:0] data_rng;
  logic [31:0] ready_rng;
  logic        bp_en;
  logic        gap_en;

  int data_errors   = 0;
  int last_errors   = 0;
  int stream_errors = 0;
  int ctrl_errors   = 0;
  int words_seen    = 0;
  int done_cnt      = 0;
  int cycle_cnt     = 0;

  fc_top u_fc_top (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] st);
    return st * 32'd1664525 + 32'd1013904223;
  endfunction

  // dot product, bias times 64, keep bits 13..6 with saturation, then ReLU
  function automatic logic [7:0] neuron_ref(input int o);
    int    acc;
    int    q;
    lane_t f;
    lane_t w;
    lane_t b;
    acc = 0;
    for (int i = 0; i < cur_in; i++) begin
      for (int l = 0; l < 4; l++) begin
        f = lane_t'(feat_words[i][8*l +: 8]);
        w = lane_t'(wgt_words[o * cur_in + i][8*l +: 8]);
        acc += int'(f) * int'(w);
      end
    end
    b = lane_t'(bias_words[o / 4][8*(o % 4) +: 8]);
    acc += int'(b) * 64;
    q = acc >>> 6;
    if (q > 127) q = 127;
    else if (q < -128) q = -128;
    if (q < 0) q = 0;
    return 8'(q);
  endfunction

  // four neurons per word, lanes past the last output stay zero
  function automatic mem_word_t word_ref(input int w);
    mem_word_t word;
    word = '0;
    for (int l = 0; l < 4; l++) begin
      if (w * 4 + l < cur_out) word[8*l +: 8] = neuron_ref(w * 4 + l);
    end
    return word;
  endfunction

  ////////////////////
  // stimulus
  ////////////////////

  task automatic fill_random(input int n_out, input int n_in);
    for (int i = 0; i < n_in; i++) begin
      data_rng = lcg_next(data_rng);
      feat_words[i] = data_rng;
    end
    for (int b = 0; b < (n_out + 3) / 4; b++) begin
      data_rng = lcg_next(data_rng);
      bias_words[b] = data_rng;
    end
    for (int k = 0; k < n_out * n_in; k++) begin
      data_rng = lcg_next(data_rng);
      wgt_words[k] = data_rng;
    end
  endtask

  // neuron 0 overflows high, neuron 1 overflows low, 2 and 3 are bias only
  task automatic fill_saturate();
    cur_out = 4;
    cur_in  = 4;
    for (int i = 0; i < 4; i++) begin
      feat_words[i]    = 32'h7f7f7f7f;
      wgt_words[i]     = 32'h7f7f7f7f;
      wgt_words[4 + i] = 32'h80808080;
      wgt_words[8 + i] = 32'h0;
      wgt_words[12 + i] = 32'h0;
    end
    bias_words[0] = 32'hfb640000;
  endtask

  // the beat transfers at the next rising edge once s_tready is high
  task automatic send_beat(input mem_word_t data, input logic last);
    if (gap_en) begin
      data_rng = lcg_next(data_rng);
      if (data_rng[18]) @(negedge clk);
    end
    s_tdata  = data;
    s_tlast  = last;
    s_tvalid = 1'b1;
    while (!s_tready) @(negedge clk);
    @(negedge clk);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic run_layer(input int n_out, input int n_in);
    int done_before;
    int seen_before;
    int n_words;
    done_before = done_cnt;
    seen_before = words_seen;
    n_words     = (n_out + 3) / 4;
    cur_out     = n_out;
    cur_in      = n_in;
    for (int w = 0; w < n_words; w++) begin
      exp_q.push_back(word_ref(w));
      last_q.push_back(w == n_words - 1);
    end
    @(negedge clk);
    out_size = out_idx_t'(n_out);
    fc_start = 1'b1;
    @(negedge clk);
    fc_start = 1'b0;
    for (int i = 0; i < n_in; i++) send_beat(feat_words[i], i == n_in - 1);
    for (int b = 0; b < n_words; b++) send_beat(bias_words[b], b == n_words - 1);
    for (int k = 0; k < n_out * n_in; k++) send_beat(wgt_words[k], k == n_out * n_in - 1);
    while (done_cnt == done_before) @(negedge clk);
    repeat (4) @(negedge clk);
    assert (done_cnt == done_before + 1) else begin
      ctrl_errors++;
      $display("fc_done pulsed %0d cycles for one run", done_cnt - done_before);
    end
    assert (words_seen - seen_before == n_words) else begin
      ctrl_errors++;
      $display("run sent %0d words instead of %0d", words_seen - seen_before, n_words);
    end
    assert (exp_q.size() == 0) else begin
      ctrl_errors++;
      $display("%0d expected words never arrived", exp_q.size());
    end
  endtask

  // output back-pressure, random when enabled
  initial begin
    m_tready  = 1'b0;
    ready_rng = 32'd38010;
    forever begin
      @(negedge clk);
      if (bp_en) begin
        ready_rng = lcg_next(ready_rng);
        m_tready  = ready_rng[21];
      end else begin
        m_tready = 1'b1;
      end
    end
  end

  ////////////////////
  // output checker
  ////////////////////

  always @(posedge clk) begin
    if (rstn && m_tvalid && m_tready) begin
      assert (exp_q.size() > 0) else begin
        stream_errors++;
        $display("output word arrived when no word was expected");
      end
      if (exp_q.size() > 0) begin
        exp_word = exp_q.pop_front();
        exp_last = last_q.pop_front();
        assert (m_tdata == exp_word) else begin
          data_errors++;
          $display("error at %0t ns: word %0d is %h, expected %h",
                   $time, words_seen, m_tdata, exp_word);
        end
        assert (m_tlast == exp_last) else begin
          last_errors++;
          $display("error at %0t ns: m_tlast is %b, expected %b", $time, m_tlast, exp_last);
        end
      end
      words_seen++;
      last_word = m_tdata;
    end
    if (rstn && fc_done) done_cnt++;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    rstn     = 1'b0;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    fc_start = 1'b0;
    out_size = '0;
    bp_en    = 1'b0;
    gap_en   = 1'b0;
    data_rng = 32'd38010;
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    assert (!s_tready && !m_tvalid && !fc_done) else begin
      ctrl_errors++;
      $display("s_tready, m_tvalid or fc_done is high after reset");
    end

    // random data, two words
    fill_random(8, 4);
    run_layer(8, 4);

    fill_saturate();
    run_layer(4, 4);
    // 127 and 0 from saturation, bias 100, ReLU of bias -5
    assert (last_word == 32'h0064007f) else begin
      data_errors++;
      $display("error at %0t ns: saturation word is %h, expected 0064007f",
               $time, last_word);
    end

    // partial last word
    fill_random(5, 3);
    run_layer(5, 3);
    assert (last_word[31:8] == 24'h0) else begin
      ctrl_errors++;
      $display("error at %0t ns: unused lanes of last word are %h", $time, last_word[31:8]);
    end

    // random output stalls and input gaps
    bp_en  = 1'b1;
    gap_en = 1'b1;
    fill_random(16, 8);
    run_layer(16, 8);
    bp_en  = 1'b0;
    gap_en = 1'b0;

    // back to back runs of different sizes
    fill_random(12, 2);
    run_layer(12, 2);
    fill_random(3, 5);
    run_layer(3, 5);

    $display("error counts: data %0d, tlast %0d, stream %0d, control %0d",
             data_errors, last_errors, stream_errors, ctrl_errors);
    if (data_errors + last_errors + stream_errors + ctrl_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* fc_layer.f */
source/fc_mem_pkg.sv
source/fc_arith_pkg.sv
source/fc_buffer_mem.sv
source/fc_stream_loader.sv
source/fc_mac_unit.sv
source/fc_result_sender.sv
source/fc_ctrl.sv
source/fc_top.sv
dv/fc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fc layer testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fc_tb \
  -f fc_layer.f -o fc_sim > build.log 2>&1 \
  && ./obj_dir/fc_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
